/* tb.f */
+incdir+common
common/arith_pkg.sv
src/msg_delay.sv
alu/req_decode.sv
alu/alu_execute.sv
alu/resp_result.sv
src/arith_delay_top.sv
sim/arith_assertions.sv
sim/arith_tb.sv

/* Makefile */
# Verilator build and run of the arithmetic unit testbench

VERILATOR ?= verilator
TOP       ?= arith_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/arith_tb.sv */
/*
 * Directed testbench for the arithmetic unit
 * LFSR operands, reference model, compare tasks and closing report
 */

`include "arith_config.svh"

module arith_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          HALF_NS        = 20;
  localparam int          RESET_CYCLES   = 8;
  localparam int          TIMEOUT_CYCLES = 200;
  localparam int          BURST_LEN      = 20;
  localparam logic [31:0] LFSR_SEED      = 32'h1b711c1e;

  logic                         clk = 1'b0;
  logic                         reset;
  logic [`ARITH_DELAY_BITS-1:0] in_delay_amt;
  logic [`ARITH_DELAY_BITS-1:0] out_delay_amt;
  logic                         in_val;
  logic                         in_rdy;
  arith_pkg::arith_req_t        in_msg;
  logic                         out_val;
  logic                         out_rdy;
  arith_pkg::arith_resp_t       out_msg;

  int                         errors     = 0;
  int                         timeouts   = 0;
  int                         cycle_cnt  = 0;
  logic [31:0]                lfsr_state = LFSR_SEED;
  logic [`ARITH_SEQ_BITS-1:0] model_seq  = '0;

  // Expected responses and edge stamps, oldest first
  arith_pkg::arith_resp_t exp_q[$];
  int                     first_q[$];
  int                     accept_q[$];

  arith_delay_top u_arith_delay_top (
    .clk(clk), .reset(reset), .in_delay_amt(in_delay_amt), .out_delay_amt(out_delay_amt),
    .in_val(in_val), .in_rdy(in_rdy), .in_msg(in_msg),
    .out_val(out_val), .out_rdy(out_rdy), .out_msg(out_msg)
  );

  always #HALF_NS clk = ~clk;

  // Rising edge count, read only away from the edge
  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // ------------------------------------------------
  // Stimulus and reference model
  // ------------------------------------------------

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_bit()};
    end
    return r;
  endfunction

  function automatic arith_pkg::arith_req_t make_req(input arith_pkg::arith_op_e op,
      input logic [`ARITH_DATA_BITS-1:0] a, input logic [`ARITH_DATA_BITS-1:0] b);
    arith_pkg::arith_req_t req;
    req.op = op;
    req.a  = a;
    req.b  = b;
    return req;
  endfunction

  function automatic arith_pkg::arith_req_t rand_req();
    logic [31:0] op_bits;
    logic [31:0] a_bits;
    logic [31:0] b_bits;
    op_bits = rand_bits(2);
    a_bits  = rand_bits(`ARITH_DATA_BITS);
    b_bits  = rand_bits(`ARITH_DATA_BITS);
    return make_req(arith_pkg::arith_op_e'(op_bits[1:0]), a_bits[`ARITH_DATA_BITS-1:0],
                    b_bits[`ARITH_DATA_BITS-1:0]);
  endfunction

  // Opcode rule modulo 2**16, tagged with the model's own count
  function automatic arith_pkg::arith_resp_t model_resp(input arith_pkg::arith_req_t req);
    arith_pkg::arith_resp_t      resp;
    logic [`ARITH_DATA_BITS-1:0] value;
    case (req.op)
      arith_pkg::OP_ADD: value = req.a + req.b;
      arith_pkg::OP_SUB: value = req.a - req.b;
      arith_pkg::OP_AND: value = req.a & req.b;
      default:           value = req.a ^ req.b;
    endcase
    resp.seq    = model_seq;
    resp.op     = req.op;
    resp.zero   = (value == '0);
    resp.result = value;
    model_seq++;
    return resp;
  endfunction

  // ------------------------------------------------
  // Compare tasks
  // ------------------------------------------------
  task automatic check_resp(input arith_pkg::arith_resp_t act,
                            input arith_pkg::arith_resp_t exp);
    if (act.seq !== exp.seq) begin
      errors++;
      $display("ERR %0t: seq got %0d expected %0d", $time, act.seq, exp.seq);
    end
    if (act.op !== exp.op) begin
      errors++;
      $display("ERR %0t: op got %0d expected %0d", $time, act.op, exp.op);
    end
    if (act.zero !== exp.zero) begin
      errors++;
      $display("ERR %0t: zero got %0b expected %0b", $time, act.zero, exp.zero);
    end
    if (act.result !== exp.result) begin
      errors++;
      $display("ERR %0t: result got %h expected %h", $time, act.result, exp.result);
    end
  endtask

  task automatic check_bit(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      errors++;
      $display("ERR %0t: %s got %0b expected %0b", $time, what, act, exp);
    end
  endtask

  // Exact match, or a lower bound
  task automatic check_latency(input int act, input int exp, input bit exact);
    if (exact ? (act != exp) : (act < exp)) begin
      errors++;
      $display("ERR %0t: latency %0d cycles, %s %0d", $time, act,
               exact ? "expected" : "minimum", exp);
    end
  endtask

  // ------------------------------------------------
  // Stream tasks, each starts and ends at a falling edge
  // ------------------------------------------------
  task automatic send_req(input arith_pkg::arith_req_t req);
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    in_val = 1'b1;
    in_msg = req;
    first_q.push_back(cycle_cnt + 1);
    while (!taken && waited < TIMEOUT_CYCLES) begin
      // Sample just before the rising edge
      #(HALF_NS - 1);
      if (in_rdy) begin
        taken = 1'b1;
        accept_q.push_back(cycle_cnt + 1);
        exp_q.push_back(model_resp(req));
      end
      @(negedge clk);
      waited++;
    end
    in_val = 1'b0;
    if (!taken) begin
      timeouts++;
      void'(first_q.pop_back());
      $display("Request was not accepted within timeout");
    end
  endtask

  task automatic recv_resp(input bit rand_rdy, input bit exact);
    int                     waited;
    int                     out_edge;
    logic                   got;
    arith_pkg::arith_resp_t act;
    waited   = 0;
    out_edge = 0;
    got      = 1'b0;
    act      = '0;
    while (!got && waited < TIMEOUT_CYCLES) begin
      out_rdy = rand_rdy ? lfsr_bit() : 1'b1;
      #(HALF_NS - 1);
      if (out_val && out_rdy) begin
        got      = 1'b1;
        out_edge = cycle_cnt + 1;
        act      = out_msg;
      end
      @(negedge clk);
      waited++;
    end
    out_rdy = 1'b1;
    if (!got) begin
      timeouts++;
      $display("No response within timeout");
    end else if (exp_q.size() == 0) begin
      errors++;
      $display("ERR %0t: response with no request outstanding", $time);
    end else begin
      check_resp(act, exp_q.pop_front());
      check_latency(out_edge - first_q.pop_front(),
                    3 + int'(in_delay_amt) + int'(out_delay_amt), 1'b0);
      if (exact) begin
        check_latency(out_edge - accept_q.pop_front(), 3, 1'b1);
      end else begin
        void'(accept_q.pop_front());
      end
    end
  endtask

  // ------------------------------------------------
  // Directed tests
  // ------------------------------------------------
  task automatic test_after_reset();
    #(HALF_NS - 1);
    check_bit(out_val, 1'b0, "out_val after reset");
    @(negedge clk);
  endtask

  // First response here also carries seq 0
  task automatic test_each_opcode();
    arith_pkg::arith_req_t req;
    for (int op = 0; op < 4; op++) begin
      req    = rand_req();
      req.op = arith_pkg::arith_op_e'(op);
      send_req(req);
      recv_resp(1'b0, 1'b1);
    end
  endtask

  task automatic test_zero_flag();
    arith_pkg::arith_req_t       reqs[6];
    logic [`ARITH_DATA_BITS-1:0] v;
    v       = 16'h1234;
    reqs[0] = make_req(arith_pkg::OP_ADD, v, ~v + 1'b1);
    reqs[1] = make_req(arith_pkg::OP_SUB, 16'h5a5a, 16'h5a5a);
    reqs[2] = make_req(arith_pkg::OP_XOR, 16'hc3c3, 16'hc3c3);
    reqs[3] = make_req(arith_pkg::OP_AND, 16'hffff, 16'h0000);
    // Near misses keep the flag clear
    reqs[4] = make_req(arith_pkg::OP_SUB, 16'h0001, 16'h0000);
    reqs[5] = make_req(arith_pkg::OP_AND, 16'h8000, 16'hffff);
    foreach (reqs[i]) begin
      send_req(reqs[i]);
      recv_resp(1'b0, 1'b1);
    end
  endtask

  // Back-to-back requests against a randomly stalling sink
  task automatic test_burst(input int count);
    arith_pkg::arith_req_t burst[$];
    for (int i = 0; i < count; i++) begin
      burst.push_back(rand_req());
    end
    fork
      begin
        for (int i = 0; i < count; i++) send_req(burst[i]);
      end
      begin
        for (int j = 0; j < count; j++) recv_resp(1'b1, 1'b0);
      end
    join
  endtask

  task automatic test_backpressure();
    out_rdy = 1'b0;
    for (int i = 0; i < 3; i++) begin
      send_req(rand_req());
    end
    // Sink held off for 10 cycles in all
    repeat (6) @(negedge clk);
    #(HALF_NS - 1);
    check_bit(in_rdy, 1'b0, "in_rdy with three requests held");
    check_bit(out_val, 1'b1, "out_val while stalled");
    @(negedge clk);
    for (int i = 0; i < 3; i++) begin
      recv_resp(1'b0, 1'b0);
    end
  endtask

  initial begin
    int assert_fails;
    reset         = 1'b1;
    in_delay_amt  = '0;
    out_delay_amt = '0;
    in_val        = 1'b0;
    in_msg        = '0;
    out_rdy       = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_after_reset();
    test_each_opcode();
    test_zero_flag();
    test_burst(BURST_LEN);
    // Both delays active, changed while the pipeline is empty
    in_delay_amt  = 3;
    out_delay_amt = 2;
    test_burst(8);
    in_delay_amt  = '0;
    out_delay_amt = '0;
    test_backpressure();
    assert_fails = int'(u_arith_delay_top.u_assertions.fail_count);
    $display("Errors: %0d, timeouts: %0d, assertion failures: %0d",
             errors, timeouts, assert_fails);
    if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* sim/arith_assertions.sv */
/*
 * Handshake assertions for the arithmetic unit top level
 * Stalled streams hold, output idle after reset
 */

module arith_assertions (
  input logic                   clk,
  input logic                   reset,
  input logic                   in_val,
  input logic                   in_rdy,
  input arith_pkg::arith_req_t  in_msg,
  input logic                   out_val,
  input logic                   out_rdy,
  input arith_pkg::arith_resp_t out_msg
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failed checks so far, read at the end of the run
  int unsigned fail_count = 0;

  // --------------------------------------------------
  // Stream stability
  // --------------------------------------------------
  a_out_hold: assert property (@(posedge clk) disable iff (reset)
      (out_val && !out_rdy) |=> (out_val && $stable(out_msg)))
    else begin
      fail_count++;
      $error("Output stream changed while stalled");
    end

  // Source side is held by the testbench driver
  a_in_hold: assert property (@(posedge clk) disable iff (reset)
      (in_val && !in_rdy) |=> (in_val && $stable(in_msg)))
    else begin
      fail_count++;
      $error("Input stream changed while stalled");
    end

  a_reset_idle: assert property (@(posedge clk) reset |=> !out_val)
    else begin
      fail_count++;
      $error("out_val high in the cycle after reset");
    end

endmodule

bind arith_delay_top arith_assertions u_assertions (
  .clk(clk), .reset(reset), .in_val(in_val), .in_rdy(in_rdy), .in_msg(in_msg),
  .out_val(out_val), .out_rdy(out_rdy), .out_msg(out_msg)
);

/* src/arith_delay_top.sv */
/*
 * Top level of the arithmetic unit
 * Input delay, decode, execute, result and output delay in a chain
 */

`include "arith_config.svh"

module arith_delay_top (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [`ARITH_DELAY_BITS-1:0] in_delay_amt,
  input  logic [`ARITH_DELAY_BITS-1:0] out_delay_amt,
  input  logic                         in_val,
  output logic                         in_rdy,
  input  arith_pkg::arith_req_t        in_msg,
  output logic                         out_val,
  input  logic                         out_rdy,
  output arith_pkg::arith_resp_t       out_msg
);

  // Input delay to decode
  logic                        dly_val;
  logic                        dly_rdy;
  arith_pkg::arith_req_t       dly_msg;

  // Decode to execute
  logic                        dec_val;
  logic                        dec_rdy;
  arith_pkg::exec_ctl_t        dec_ctl;

  // Execute to result
  logic                        exe_val;
  logic                        exe_rdy;
  arith_pkg::arith_op_e        exe_op;
  logic [`ARITH_DATA_BITS-1:0] exe_result;

  // Result to output delay
  logic                        res_val;
  logic                        res_rdy;
  arith_pkg::arith_resp_t      res_msg;

  // ------------------------------------------------
  // Request side
  // ------------------------------------------------
  msg_delay #(.msg_bits($bits(arith_pkg::arith_req_t))) u_in_delay (
    .clk(clk), .reset(reset), .delay_amt(in_delay_amt),
    .in_val(in_val), .in_rdy(in_rdy), .in_msg(in_msg),
    .out_val(dly_val), .out_rdy(dly_rdy), .out_msg(dly_msg)
  );

  req_decode u_decode (
    .clk(clk), .reset(reset),
    .in_val(dly_val), .in_rdy(dly_rdy), .in_msg(dly_msg),
    .out_val(dec_val), .out_rdy(dec_rdy), .out_ctl(dec_ctl)
  );

  alu_execute u_execute (
    .clk(clk), .reset(reset),
    .in_val(dec_val), .in_rdy(dec_rdy), .in_ctl(dec_ctl),
    .out_val(exe_val), .out_rdy(exe_rdy), .out_op(exe_op), .out_result(exe_result)
  );

  // ------------------------------------------------
  // Response side
  // ------------------------------------------------
  resp_result u_result (
    .clk(clk), .reset(reset),
    .in_val(exe_val), .in_rdy(exe_rdy), .in_op(exe_op), .in_result(exe_result),
    .out_val(res_val), .out_rdy(res_rdy), .out_msg(res_msg)
  );

  msg_delay #(.msg_bits($bits(arith_pkg::arith_resp_t))) u_out_delay (
    .clk(clk), .reset(reset), .delay_amt(out_delay_amt),
    .in_val(res_val), .in_rdy(res_rdy), .in_msg(res_msg),
    .out_val(out_val), .out_rdy(out_rdy), .out_msg(out_msg)
  );

endmodule

/* alu/resp_result.sv */
/*
 * Result stage
 * Tags each result with a sequence number and a zero flag
 */

`include "arith_config.svh"

module resp_result (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        in_val,
  output logic                        in_rdy,
  input  arith_pkg::arith_op_e        in_op,
  input  logic [`ARITH_DATA_BITS-1:0] in_result,
  output logic                        out_val,
  input  logic                        out_rdy,
  output arith_pkg::arith_resp_t      out_msg
);

  logic [`ARITH_SEQ_BITS-1:0] seq;
  logic                       full;
  logic                       accept;

  assign in_rdy = !full || out_rdy;
  assign accept = in_val && in_rdy;

  // Entry valid and sequence counter
  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
      seq  <= '0;
    end else begin
      if (in_rdy) begin
        full <= in_val;
      end
      // Wraps naturally at the counter width
      if (accept) begin
        seq <= seq + 1'b1;
      end
    end
  end

  // Response register, tagged with the count before it advances
  always_ff @(posedge clk) begin
    if (accept) begin
      out_msg.seq    <= seq;
      out_msg.op     <= in_op;
      out_msg.zero   <= (in_result == '0);
      out_msg.result <= in_result;
    end
  end

  assign out_val = full;

endmodule

/* alu/alu_execute.sv */
/*
 * Execute stage
 * Adder with optional b inversion and carry, or AND / XOR logic
 */

`include "arith_config.svh"

module alu_execute (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        in_val,
  output logic                        in_rdy,
  input  arith_pkg::exec_ctl_t        in_ctl,
  output logic                        out_val,
  input  logic                        out_rdy,
  output arith_pkg::arith_op_e        out_op,
  output logic [`ARITH_DATA_BITS-1:0] out_result
);

  logic [`ARITH_DATA_BITS-1:0] b_eff;
  logic [`ARITH_DATA_BITS-1:0] carry_ext;
  logic [`ARITH_DATA_BITS-1:0] sum;
  logic [`ARITH_DATA_BITS-1:0] logic_res;
  logic [`ARITH_DATA_BITS-1:0] result_next;
  logic                        full;

  assign in_rdy = !full || out_rdy;

  // ------------------------------------------------
  // Datapath
  // ------------------------------------------------

  // Subtract uses the inverted operand
  assign b_eff     = in_ctl.invert_b ? ~in_ctl.b : in_ctl.b;
  assign carry_ext = {{(`ARITH_DATA_BITS-1){1'b0}}, in_ctl.carry_in};

  // Carry out dropped, result is modulo 2**ARITH_DATA_BITS
  assign sum = in_ctl.a + b_eff + carry_ext;

  assign logic_res = in_ctl.logic_xor ? (in_ctl.a ^ in_ctl.b)
                                      : (in_ctl.a & in_ctl.b);

  assign result_next = in_ctl.use_logic ? logic_res : sum;

  // ------------------------------------------------
  // Output register
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (in_rdy) begin
      full <= in_val;
    end
  end

  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      out_op     <= in_ctl.op;
      out_result <= result_next;
    end
  end

  assign out_val = full;

endmodule

/* alu/req_decode.sv */
/*
 * Decode stage
 * One-entry register that maps the opcode to ALU controls
 */

module req_decode (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  in_val,
  output logic                  in_rdy,
  input  arith_pkg::arith_req_t in_msg,
  output logic                  out_val,
  input  logic                  out_rdy,
  output arith_pkg::exec_ctl_t  out_ctl
);

  arith_pkg::exec_ctl_t ctl_next;
  logic                 full;

  // Free slot, or the held entry leaves this cycle
  assign in_rdy = !full || out_rdy;

  // ------------------------------------------------
  // Opcode to controls
  // ------------------------------------------------
  always_comb begin
    ctl_next           = '0;
    ctl_next.op        = in_msg.op;
    ctl_next.a         = in_msg.a;
    ctl_next.b         = in_msg.b;
    case (in_msg.op)
      arith_pkg::OP_SUB: begin
        // a + ~b + 1
        ctl_next.invert_b = 1'b1;
        ctl_next.carry_in = 1'b1;
      end
      arith_pkg::OP_AND: begin
        ctl_next.use_logic = 1'b1;
      end
      arith_pkg::OP_XOR: begin
        ctl_next.use_logic = 1'b1;
        ctl_next.logic_xor = 1'b1;
      end
      default: begin
        // ADD, plain adder with no carry
        ctl_next.use_logic = 1'b0;
      end
    endcase
  end

  // Valid flag
  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (in_rdy) begin
      full <= in_val;
    end
  end

  // Payload, loaded on each accepted request
  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      out_ctl <= ctl_next;
    end
  end

  assign out_val = full;

endmodule

/* src/msg_delay.sv */
/*
 * Programmable fixed delay on a valid/ready stream
 * Two-state FSM with a down-counter, message passes through untouched
 */

`include "arith_config.svh"

module msg_delay #(
  parameter int msg_bits = 1
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [`ARITH_DELAY_BITS-1:0] delay_amt,
  input  logic                         in_val,
  output logic                         in_rdy,
  input  logic [msg_bits-1:0]          in_msg,
  output logic                         out_val,
  input  logic                         out_rdy,
  output logic [msg_bits-1:0]          out_msg
);

  typedef enum logic {
    ST_IDLE  = 1'b0,
    ST_DELAY = 1'b1
  } state_e;

  state_e                       state;
  state_e                       state_next;
  logic [`ARITH_DELAY_BITS-1:0] count;
  logic [`ARITH_DELAY_BITS-1:0] count_next;
  logic                         count_en;
  logic                         pass_now;

  // Zero delay and a ready sink, so the message goes straight through
  assign pass_now = in_val && out_rdy && (delay_amt == '0);

  // ------------------------------------------------
  // State and counter registers
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      count <= '0;
    end else begin
      state <= state_next;
      if (count_en) begin
        count <= count_next;
      end
    end
  end

  // ------------------------------------------------
  // Next state and handshake outputs
  // ------------------------------------------------
  always_comb begin
    state_next = state;
    count_en   = 1'b0;
    count_next = count;
    in_rdy     = 1'b0;
    out_val    = 1'b0;
    case (state)
      ST_IDLE: begin
        // Only a zero delay exposes the message in the first cycle
        in_rdy  = out_rdy && (delay_amt == '0);
        out_val = in_val && (delay_amt == '0);
        if (in_val && !pass_now) begin
          state_next = ST_DELAY;
          count_en   = 1'b1;
          // First cycle already counts toward the delay
          count_next = (delay_amt != '0) ? delay_amt - 1'b1 : '0;
        end
      end
      ST_DELAY: begin
        // Hold back until the counter runs out
        in_rdy  = out_rdy && (count == '0);
        out_val = in_val && (count == '0);
        if (count != '0) begin
          count_en   = 1'b1;
          count_next = count - 1'b1;
        end
        // Back to idle once the message is taken
        if (in_val && out_rdy && (count == '0)) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  // Message is never copied
  assign out_msg = in_msg;

endmodule

/* common/arith_pkg.sv */
/*
 * Shared types for the arithmetic unit
 * Opcode enum, request, decoded control and response structs
 */

`include "arith_config.svh"

package arith_pkg;

  // ------------------------------------------------
  // Opcodes
  // ------------------------------------------------
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_AND = 2'd2,
    OP_XOR = 2'd3
  } arith_op_e;

  // Request as it enters the unit
  typedef struct packed {
    arith_op_e                   op;
    logic [`ARITH_DATA_BITS-1:0] a;
    logic [`ARITH_DATA_BITS-1:0] b;
  } arith_req_t;

  // Decoded ALU controls, operands ride along
  typedef struct packed {
    arith_op_e                   op;
    logic                        use_logic;  // logic result instead of adder
    logic                        invert_b;
    logic                        carry_in;
    logic                        logic_xor;  // XOR instead of AND
    logic [`ARITH_DATA_BITS-1:0] a;
    logic [`ARITH_DATA_BITS-1:0] b;
  } exec_ctl_t;

  // Tagged response
  typedef struct packed {
    logic [`ARITH_SEQ_BITS-1:0]  seq;
    arith_op_e                   op;
    logic                        zero;
    logic [`ARITH_DATA_BITS-1:0] result;
  } arith_resp_t;

endpackage

/* common/arith_config.svh */
/*
 * Width settings for the arithmetic request/response unit
 * Data, sequence tag and delay counter widths
 */

`ifndef ARITH_CONFIG_SVH
`define ARITH_CONFIG_SVH

// Operand and result width
`define ARITH_DATA_BITS 16

// Sequence tag width, counter wraps at 2**ARITH_SEQ_BITS
`define ARITH_SEQ_BITS 8

// Width of the run-time delay amount on each stream
`define ARITH_DELAY_BITS 32

`endif
